//--- list.f
design/w_buf_pkg.sv
design/sync_fifo.sv
design/w_forward_ctrl.sv
design/axi4_w_buffer.sv
verification/w_buffer_properties.sv
verification/tb_axi4_w_buffer.sv

//--- Makefile
# Verilator build and run of the W channel buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_axi4_w_buffer
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(wildcard design/*.sv) $(wildcard verification/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only when the pass line shows up in the simulation output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_axi4_w_buffer.sv
// ---------------------------------------------------------------------------
// Directed tests of axi4_w_buffer at the default buffer depths
// Stops at the first mismatch or timeout
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_axi4_w_buffer;

  localparam int unsigned W_BUF_DEPTH   = 4;
  localparam int unsigned L1_FIFO_DEPTH = 8;
  localparam int          TIMEOUT       = 100;

  // Beat expected on the master port, with the master it must be routed to
  typedef struct packed {
    logic               master;
    w_buf_pkg::w_beat_t beat;
  } exp_beat_t;

  logic                         axi4_aclk;
  logic                         axi4_arstn;
  logic                         l1_accept_i;
  logic                         l1_drop_i;
  logic                         l1_master_i;
  logic [w_buf_pkg::ID_W-1:0]   l1_id_i;
  logic                         l1_prefetch_i;
  logic                         l1_hit_i;
  logic                         l1_done_o;
  logic                         input_stall_o;
  logic                         master_select_o;
  logic                         b_drop_o;
  logic                         b_done_i;
  logic [w_buf_pkg::ID_W-1:0]   id_o;
  logic                         prefetch_o;
  logic                         hit_o;
  logic [w_buf_pkg::DATA_W-1:0] s_axi4_wdata;
  logic                         s_axi4_wvalid;
  logic                         s_axi4_wready;
  logic [w_buf_pkg::STRB_W-1:0] s_axi4_wstrb;
  logic                         s_axi4_wlast;
  logic [w_buf_pkg::USER_W-1:0] s_axi4_wuser;
  logic [w_buf_pkg::DATA_W-1:0] m_axi4_wdata;
  logic                         m_axi4_wvalid;
  logic                         m_axi4_wready;
  logic [w_buf_pkg::STRB_W-1:0] m_axi4_wstrb;
  logic                         m_axi4_wlast;
  logic [w_buf_pkg::USER_W-1:0] m_axi4_wuser;

  exp_beat_t   exp_q[$];
  exp_beat_t   mon_exp;
  logic [31:0] rng_state;

  axi4_w_buffer #(
    .W_BUF_DEPTH   ( W_BUF_DEPTH   ),
    .L1_FIFO_DEPTH ( L1_FIFO_DEPTH )
  ) i_axi4_w_buffer (
    .axi4_aclk       ( axi4_aclk       ),
    .axi4_arstn      ( axi4_arstn      ),
    .l1_accept_i     ( l1_accept_i     ),
    .l1_drop_i       ( l1_drop_i       ),
    .l1_master_i     ( l1_master_i     ),
    .l1_id_i         ( l1_id_i         ),
    .l1_prefetch_i   ( l1_prefetch_i   ),
    .l1_hit_i        ( l1_hit_i        ),
    .l1_done_o       ( l1_done_o       ),
    .input_stall_o   ( input_stall_o   ),
    .master_select_o ( master_select_o ),
    .b_drop_o        ( b_drop_o        ),
    .b_done_i        ( b_done_i        ),
    .id_o            ( id_o            ),
    .prefetch_o      ( prefetch_o      ),
    .hit_o           ( hit_o           ),
    .s_axi4_wdata    ( s_axi4_wdata    ),
    .s_axi4_wvalid   ( s_axi4_wvalid   ),
    .s_axi4_wready   ( s_axi4_wready   ),
    .s_axi4_wstrb    ( s_axi4_wstrb    ),
    .s_axi4_wlast    ( s_axi4_wlast    ),
    .s_axi4_wuser    ( s_axi4_wuser    ),
    .m_axi4_wdata    ( m_axi4_wdata    ),
    .m_axi4_wvalid   ( m_axi4_wvalid   ),
    .m_axi4_wready   ( m_axi4_wready   ),
    .m_axi4_wstrb    ( m_axi4_wstrb    ),
    .m_axi4_wlast    ( m_axi4_wlast    ),
    .m_axi4_wuser    ( m_axi4_wuser    )
  );

  always #2 axi4_aclk = ~axi4_aclk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic report_timeout(input string what);
    report_failure($sformatf("Timed out at %0t waiting for %s", $time, what));
  endtask

  task automatic check(input string what, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("[ERROR] %0t: %s is 0x%0h, expected 0x%0h",
                               $time, what, actual, expected));
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge axi4_aclk);
    #1;
  endtask

  // Every master handshake must match the oldest expected beat
  always @(negedge axi4_aclk) begin
    if (axi4_arstn && m_axi4_wvalid && m_axi4_wready) begin
      if (exp_q.size() == 0) begin
        report_failure($sformatf("Unexpected beat on the master W channel at %0t", $time));
      end else begin
        mon_exp = exp_q.pop_front();
        check("m_axi4_wdata", 64'(m_axi4_wdata), 64'(mon_exp.beat.data));
        check("m_axi4_wstrb", 64'(m_axi4_wstrb), 64'(mon_exp.beat.strb));
        check("m_axi4_wuser", 64'(m_axi4_wuser), 64'(mon_exp.beat.user));
        check("m_axi4_wlast", 64'(m_axi4_wlast), 64'(mon_exp.beat.last));
        check("master_select_o", 64'(master_select_o), 64'(mon_exp.master));
      end
    end
  end

  task automatic send_beats(input int len, input logic expect_out, input logic master);
    w_buf_pkg::w_beat_t beat;
    exp_beat_t          e;
    logic [31:0]        r;
    int                 waited;
    for (int i = 0; i < len; i++) begin
      r         = next_rand();
      beat.data = next_rand();
      beat.strb = r[w_buf_pkg::STRB_W-1:0];
      beat.user = r[w_buf_pkg::USER_W+7:8];
      beat.last = (i == len - 1);
      s_axi4_wvalid = 1'b1;
      s_axi4_wdata  = beat.data;
      s_axi4_wstrb  = beat.strb;
      s_axi4_wuser  = beat.user;
      s_axi4_wlast  = beat.last;
      waited = 0;
      @(negedge axi4_aclk);
      while (!s_axi4_wready) begin
        if (waited == TIMEOUT) begin
          report_timeout("s_axi4_wready");
        end
        waited++;
        @(negedge axi4_aclk);
      end
      if (expect_out) begin
        e.master = master;
        e.beat   = beat;
        exp_q.push_back(e);
      end
      next_cycle();
    end
    s_axi4_wvalid = 1'b0;
    s_axi4_wlast  = 1'b0;
  endtask

  task automatic send_decision(input logic drop, input logic master,
                               input logic [w_buf_pkg::ID_W-1:0] id, input logic prefetch,
                               input logic hit, input logic expect_done);
    l1_accept_i   = ~drop;
    l1_drop_i     = drop;
    l1_master_i   = master;
    l1_id_i       = id;
    l1_prefetch_i = prefetch;
    l1_hit_i      = hit;
    @(negedge axi4_aclk);
    check("l1_done_o", 64'(l1_done_o), 64'(expect_done));
    next_cycle();
    l1_accept_i = 1'b0;
    l1_drop_i   = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == TIMEOUT) begin
        report_timeout("the expected master beats");
      end
      waited++;
      next_cycle();
    end
  endtask

  // Plays the B sender: holds b_done_i low for a while, then answers
  task automatic answer_drop(input logic [w_buf_pkg::ID_W-1:0] id, input logic hit,
                             input logic prefetch, input int hold);
    int waited;
    waited = 0;
    @(negedge axi4_aclk);
    while (!b_drop_o) begin
      if (waited == TIMEOUT) begin
        report_timeout("b_drop_o");
      end
      waited++;
      @(negedge axi4_aclk);
    end
    check("id_o", 64'(id_o), 64'(id));
    check("hit_o", 64'(hit_o), 64'(hit));
    check("prefetch_o", 64'(prefetch_o), 64'(prefetch));
    for (int i = 0; i < hold; i++) begin
      next_cycle();
      @(negedge axi4_aclk);
      check("b_drop_o held", 64'(b_drop_o), 64'd1);
    end
    next_cycle();
    b_done_i = 1'b1;
    next_cycle();
    b_done_i = 1'b0;
    @(negedge axi4_aclk);
    check("b_drop_o after b_done_i", 64'(b_drop_o), 64'd0);
    next_cycle();
  endtask

  task automatic after_reset_outputs();
    @(negedge axi4_aclk);
    check("m_axi4_wvalid", 64'(m_axi4_wvalid), 64'd0);
    check("b_drop_o", 64'(b_drop_o), 64'd0);
    check("l1_done_o", 64'(l1_done_o), 64'd0);
    check("input_stall_o", 64'(input_stall_o), 64'd0);
    check("s_axi4_wready", 64'(s_axi4_wready), 64'd1);
    next_cycle();
  endtask

  task automatic accepted_burst();
    m_axi4_wready = 1'b1;
    send_beats(3, 1'b1, 1'b1);
    send_decision(1'b0, 1'b1, 4'h2, 1'b0, 1'b1, 1'b1);
    wait_drain();
  endtask

  task automatic dropped_burst();
    m_axi4_wready = 1'b1;
    send_beats(3, 1'b0, 1'b0);
    send_decision(1'b1, 1'b0, 4'hA, 1'b0, 1'b1, 1'b1);
    answer_drop(4'hA, 1'b1, 1'b0, 3);
  endtask

  task automatic mixed_order();
    m_axi4_wready = 1'b1;
    send_decision(1'b0, 1'b0, 4'h1, 1'b0, 1'b0, 1'b1);
    send_decision(1'b1, 1'b0, 4'h3, 1'b1, 1'b0, 1'b1);
    send_decision(1'b0, 1'b1, 4'h5, 1'b0, 1'b1, 1'b1);
    send_beats(2, 1'b1, 1'b0);
    send_beats(2, 1'b0, 1'b0);
    send_beats(3, 1'b1, 1'b1);
    answer_drop(4'h3, 1'b0, 1'b1, 1);
    wait_drain();
  endtask

  task automatic master_backpressure();
    m_axi4_wready = 1'b0;
    send_decision(1'b0, 1'b1, 4'h7, 1'b0, 1'b0, 1'b1);
    send_beats(int'(W_BUF_DEPTH), 1'b1, 1'b1);
    // Buffer is full and the head beat must not move
    for (int i = 0; i < 3; i++) begin
      @(negedge axi4_aclk);
      check("s_axi4_wready when full", 64'(s_axi4_wready), 64'd0);
      check("m_axi4_wvalid stalled", 64'(m_axi4_wvalid), 64'd1);
      check("stalled m_axi4_wdata", 64'(m_axi4_wdata), 64'(exp_q[0].beat.data));
      next_cycle();
    end
    m_axi4_wready = 1'b1;
    wait_drain();
  endtask

  task automatic decision_fifo_stall();
    m_axi4_wready = 1'b1;
    for (int i = 0; i < int'(L1_FIFO_DEPTH); i++) begin
      send_decision(1'b0, i[0], i[3:0], 1'b0, 1'b0, 1'b1);
    end
    @(negedge axi4_aclk);
    check("input_stall_o when full", 64'(input_stall_o), 64'd1);
    next_cycle();
    send_decision(1'b0, 1'b0, 4'hF, 1'b0, 1'b0, 1'b0);
    // Single-beat bursts release the queued decisions
    for (int i = 0; i < int'(L1_FIFO_DEPTH); i++) begin
      send_beats(1, 1'b1, i[0]);
    end
    wait_drain();
    @(negedge axi4_aclk);
    check("input_stall_o after drain", 64'(input_stall_o), 64'd0);
    next_cycle();
  endtask

  initial begin
    rng_state     = 32'd24;
    axi4_aclk     = 1'b0;
    axi4_arstn    = 1'b0;
    l1_accept_i   = 1'b0;
    l1_drop_i     = 1'b0;
    l1_master_i   = 1'b0;
    l1_id_i       = '0;
    l1_prefetch_i = 1'b0;
    l1_hit_i      = 1'b0;
    b_done_i      = 1'b0;
    s_axi4_wdata  = '0;
    s_axi4_wvalid = 1'b0;
    s_axi4_wstrb  = '0;
    s_axi4_wlast  = 1'b0;
    s_axi4_wuser  = '0;
    m_axi4_wready = 1'b0;
    repeat (2) @(posedge axi4_aclk);
    #1;
    axi4_arstn = 1'b1;
    after_reset_outputs();
    accepted_burst();
    dropped_burst();
    mixed_order();
    master_backpressure();
    decision_fifo_stall();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- verification/w_buffer_properties.sv
// ---------------------------------------------------------------------------
// Protocol rules of w_forward_ctrl bound into every instance
// Rules are checked only while axi4_arstn is high
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module w_buffer_properties (
  input logic                    axi4_aclk,
  input logic                    axi4_arstn,
  input w_buf_pkg::w_beat_t      beat_i,
  input logic                    beat_valid_i,
  input logic                    beat_pop_o,
  input w_buf_pkg::l1_decision_t dec_i,
  input logic                    dec_valid_i,
  input logic                    dec_pop_o,
  input w_buf_pkg::w_beat_t      m_beat_o,
  input logic                    m_valid_o,
  input logic                    m_ready_i,
  input logic                    b_drop_o,
  input logic                    b_done_i
);

  // B sender request and its decision are held until b_done_i
  b_drop_held: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    b_drop_o && !b_done_i |=> b_drop_o && $stable(dec_i))
    else $error("b_drop_o or its decision changed before b_done_i");

  // A burst is either forwarded or reported as dropped
  no_forward_while_drop: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    !(m_valid_o && b_drop_o))
    else $error("m_valid_o and b_drop_o high together");

  stalled_beat_stable: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o))
    else $error("Master beat changed while stalled");

  // Accepted decisions leave with the pop of their last beat
  // Dropped ones leave on b_done_i
  dec_pop_reason: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    dec_pop_o |-> dec_valid_i &&
      ((dec_i.kind == w_buf_pkg::DEC_ACCEPT && beat_valid_i && beat_pop_o && beat_i.last) ||
       (dec_i.kind == w_buf_pkg::DEC_DROP && b_drop_o && b_done_i)))
    else $error("Decision popped without last beat or b_done_i");

endmodule

bind w_forward_ctrl w_buffer_properties u_w_buffer_properties (
  .axi4_aclk    ( axi4_aclk    ),
  .axi4_arstn   ( axi4_arstn   ),
  .beat_i       ( beat_i       ),
  .beat_valid_i ( beat_valid_i ),
  .beat_pop_o   ( beat_pop_o   ),
  .dec_i        ( dec_i        ),
  .dec_valid_i  ( dec_valid_i  ),
  .dec_pop_o    ( dec_pop_o    ),
  .m_beat_o     ( m_beat_o     ),
  .m_valid_o    ( m_valid_o    ),
  .m_ready_i    ( m_ready_i    ),
  .b_drop_o     ( b_drop_o     ),
  .b_done_i     ( b_done_i     )
);

//--- design/axi4_w_buffer.sv
// --------------------------------------------------------------------------
// W channel buffer of an address-translating AXI4 slave port
// L1 TLB decisions must arrive in the same order as the W bursts
// At most one of l1_accept_i and l1_drop_i is high in a cycle
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module axi4_w_buffer #(
  parameter int unsigned W_BUF_DEPTH   = 4,
  parameter int unsigned L1_FIFO_DEPTH = 8
) (
  input  logic                          axi4_aclk,
  input  logic                          axi4_arstn,

  // L1 TLB interface
  input  logic                          l1_accept_i,
  input  logic                          l1_drop_i,
  input  logic                          l1_master_i,
  input  logic [w_buf_pkg::ID_W-1:0]    l1_id_i,
  input  logic                          l1_prefetch_i,
  input  logic                          l1_hit_i,
  output logic                          l1_done_o,
  output logic                          input_stall_o,
  output logic                          master_select_o,

  // B sender interface
  output logic                          b_drop_o,
  input  logic                          b_done_i,
  output logic [w_buf_pkg::ID_W-1:0]    id_o,
  output logic                          prefetch_o,
  output logic                          hit_o,

  // Slave W channel
  input  logic [w_buf_pkg::DATA_W-1:0]  s_axi4_wdata,
  input  logic                          s_axi4_wvalid,
  output logic                          s_axi4_wready,
  input  logic [w_buf_pkg::STRB_W-1:0]  s_axi4_wstrb,
  input  logic                          s_axi4_wlast,
  input  logic [w_buf_pkg::USER_W-1:0]  s_axi4_wuser,

  // Master W channel
  output logic [w_buf_pkg::DATA_W-1:0]  m_axi4_wdata,
  output logic                          m_axi4_wvalid,
  input  logic                          m_axi4_wready,
  output logic [w_buf_pkg::STRB_W-1:0]  m_axi4_wstrb,
  output logic                          m_axi4_wlast,
  output logic [w_buf_pkg::USER_W-1:0]  m_axi4_wuser
);

  localparam int unsigned BEAT_W = $bits(w_buf_pkg::w_beat_t);
  localparam int unsigned DEC_W  = $bits(w_buf_pkg::l1_decision_t);

  w_buf_pkg::w_beat_t      w_in;
  w_buf_pkg::w_beat_t      w_head;
  w_buf_pkg::w_beat_t      m_beat;
  logic                    w_head_valid;
  logic                    w_pop;

  w_buf_pkg::l1_decision_t dec_in;
  w_buf_pkg::l1_decision_t dec_head;
  logic                    dec_head_valid;
  logic                    dec_pop;
  logic                    dec_ready;
  logic                    l1_req;

  // Incoming beat
  assign w_in.user = s_axi4_wuser;
  assign w_in.strb = s_axi4_wstrb;
  assign w_in.data = s_axi4_wdata;
  assign w_in.last = s_axi4_wlast;

  sync_fifo #(
    .WIDTH ( BEAT_W      ),
    .DEPTH ( W_BUF_DEPTH )
  ) u_w_fifo (
    .axi4_aclk  ( axi4_aclk     ),
    .axi4_arstn ( axi4_arstn    ),
    .valid_i    ( s_axi4_wvalid ),
    .data_i     ( w_in          ),
    .ready_o    ( s_axi4_wready ),
    .valid_o    ( w_head_valid  ),
    .data_o     ( w_head        ),
    .ready_i    ( w_pop         )
  );

  // Decision entry, drop wins the kind encoding
  assign l1_req          = l1_accept_i | l1_drop_i;
  assign dec_in.prefetch = l1_prefetch_i;
  assign dec_in.hit      = l1_hit_i;
  assign dec_in.id       = l1_id_i;
  assign dec_in.master   = l1_master_i;
  assign dec_in.kind     = l1_drop_i ? w_buf_pkg::DEC_DROP : w_buf_pkg::DEC_ACCEPT;

  sync_fifo #(
    .WIDTH ( DEC_W         ),
    .DEPTH ( L1_FIFO_DEPTH )
  ) u_l1_fifo (
    .axi4_aclk  ( axi4_aclk      ),
    .axi4_arstn ( axi4_arstn     ),
    .valid_i    ( l1_req         ),
    .data_i     ( dec_in         ),
    .ready_o    ( dec_ready      ),
    .valid_o    ( dec_head_valid ),
    .data_o     ( dec_head       ),
    .ready_i    ( dec_pop        )
  );

  // Done is the push itself, a strobe while full is not acknowledged
  assign l1_done_o     = l1_req & dec_ready;
  assign input_stall_o = ~dec_ready;

  w_forward_ctrl u_w_forward_ctrl (
    .axi4_aclk       ( axi4_aclk       ),
    .axi4_arstn      ( axi4_arstn      ),
    .beat_i          ( w_head          ),
    .beat_valid_i    ( w_head_valid    ),
    .beat_pop_o      ( w_pop           ),
    .dec_i           ( dec_head        ),
    .dec_valid_i     ( dec_head_valid  ),
    .dec_pop_o       ( dec_pop         ),
    .m_beat_o        ( m_beat          ),
    .m_valid_o       ( m_axi4_wvalid   ),
    .m_ready_i       ( m_axi4_wready   ),
    .master_select_o ( master_select_o ),
    .b_drop_o        ( b_drop_o        ),
    .b_done_i        ( b_done_i        ),
    .id_o            ( id_o            ),
    .prefetch_o      ( prefetch_o      ),
    .hit_o           ( hit_o           )
  );

  // Outgoing beat
  assign m_axi4_wuser = m_beat.user;
  assign m_axi4_wstrb = m_beat.strb;
  assign m_axi4_wdata = m_beat.data;
  assign m_axi4_wlast = m_beat.last;

endmodule

//--- design/w_forward_ctrl.sv
// --------------------------------------------------------------------------
// Joins the head W beat with the head L1 decision
// Accepted bursts pass through combinationally, dropped ones are absorbed
// and then held for the B sender until b_done_i
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module w_forward_ctrl (
  input  logic                              axi4_aclk,
  input  logic                              axi4_arstn,
  // Head of the W beat FIFO
  input  w_buf_pkg::w_beat_t                beat_i,
  input  logic                              beat_valid_i,
  output logic                              beat_pop_o,
  // Head of the decision FIFO
  input  w_buf_pkg::l1_decision_t           dec_i,
  input  logic                              dec_valid_i,
  output logic                              dec_pop_o,
  // Master W channel
  output w_buf_pkg::w_beat_t                m_beat_o,
  output logic                              m_valid_o,
  input  logic                              m_ready_i,
  output logic                              master_select_o,
  // B sender
  output logic                              b_drop_o,
  input  logic                              b_done_i,
  output logic [w_buf_pkg::ID_W-1:0]        id_o,
  output logic                              prefetch_o,
  output logic                              hit_o
);

  logic w_done;
  logic b_drop_set;
  logic b_drop_clr;

  // Decision fields are always visible, the B sender samples them on b_drop_o
  assign id_o            = dec_i.id;
  assign prefetch_o      = dec_i.prefetch;
  assign hit_o           = dec_i.hit;
  assign master_select_o = dec_i.master;

  // Per cycle action on the head beat
  always_comb begin
    m_beat_o   = '0;
    m_valid_o  = 1'b0;
    beat_pop_o = 1'b0;
    w_done     = 1'b0;
    b_drop_set = 1'b0;

    if (dec_valid_i) begin
      case (dec_i.kind)
        w_buf_pkg::DEC_ACCEPT: begin
          // Forward the beat, popping on the master handshake
          m_beat_o   = beat_i;
          m_valid_o  = beat_valid_i;
          beat_pop_o = m_ready_i;
          w_done     = beat_valid_i & m_ready_i & beat_i.last;
        end
        w_buf_pkg::DEC_DROP: begin
          // Throw beats away until the last one, then wait for the B sender
          if (!b_drop_o) begin
            beat_pop_o = 1'b1;
            b_drop_set = beat_valid_i & beat_i.last;
          end
        end
        default: begin
          // Unused encoding, the head is left untouched
          beat_pop_o = 1'b0;
        end
      endcase
    end
  end

  assign b_drop_clr = b_drop_o & b_done_i;

  // Decision leaves the FIFO after its burst is fully handled
  assign dec_pop_o = w_done | b_drop_clr;

  // Level towards the B sender, held until it answers
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      b_drop_o <= 1'b0;
    end else if (b_drop_clr) begin
      b_drop_o <= 1'b0;
    end else if (b_drop_set) begin
      b_drop_o <= 1'b1;
    end
  end

endmodule

//--- design/sync_fifo.sv
// --------------------------------------------------------------------------
// Synchronous FIFO with valid/ready on both sides, DEPTH of 2 or more
// No fall-through: a pushed item is visible on the output after the edge
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 4
) (
  input  logic             axi4_aclk,
  input  logic             axi4_arstn,
  // Push side
  input  logic             valid_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             ready_o,
  // Pop side
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o,
  input  logic             ready_i
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign ready_o = (count != CNT_W'(DEPTH));
  assign valid_o = (count != '0);

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  assign data_o = mem[rd_ptr];

  // Storage array, written only on a push
  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers wrap at DEPTH so any depth works, not only powers of two
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr <= '0;
    end else if (push) begin
      if (wr_ptr == PTR_W'(DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      rd_ptr <= '0;
    end else if (pop) begin
      if (rd_ptr == PTR_W'(DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy, unchanged when push and pop coincide
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

endmodule

//--- design/w_buf_pkg.sv
// --------------------------------------------------------------------------
// Shared widths and types of the W channel buffer
// A decision is accept or drop only. L2 TLB verdicts are not supported
// --------------------------------------------------------------------------

package w_buf_pkg;

  // AXI W channel widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned USER_W = 4;

  // One W beat as held in the input buffer
  typedef struct packed {
    logic [USER_W-1:0] user;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] data;
    logic              last;
  } w_beat_t;

  // L1 TLB verdict for one burst
  typedef enum logic [1:0] {
    DEC_ACCEPT = 2'd0,
    DEC_DROP   = 2'd1
  } decision_e;

  // One entry of the decision FIFO
  // Flags and ID are handed to the B sender when the burst is dropped
  typedef struct packed {
    logic            prefetch;
    logic            hit;
    logic [ID_W-1:0] id;
    logic            master;
    decision_e       kind;
  } l1_decision_t;

endpackage
